// File: src/x86_len_decoder_defines.svh
`ifndef X86_LEN_DECODER_DEFINES_SVH
`define X86_LEN_DECODER_DEFINES_SVH

// Byte queue and decode window sizes
`define QUEUE_BYTES     16
`define WINDOW_BYTES    12          // Longest supported instruction
`define CLASS_BYTES     6           // Five prefixes plus the opcode
`define WORD_BITS       32          // Four code bytes per input word

// Lock and string prefixes
`define PFX_LOCK        8'hF0
`define PFX_REPNE       8'hF2
`define PFX_REP         8'hF3

// Segment overrides
`define PFX_CS          8'h2E
`define PFX_SS          8'h36
`define PFX_DS          8'h3E
`define PFX_ES          8'h26
`define PFX_FS          8'h64
`define PFX_GS          8'h65

// Size overrides
`define PFX_OPSIZE      8'h66
`define PFX_ADDRSIZE    8'h67

`endif

// File: src/x86_decode_pkg.sv
`include "x86_len_decoder_defines.svh"

package x86_decode_pkg;

    // Prefix group of one code byte
    typedef enum logic [2:0] {
        GRP_NONE     = 3'd0,
        GRP_LOCK     = 3'd1,
        GRP_REP      = 3'd2,        // Both rep and repne
        GRP_SEG      = 3'd3,
        GRP_OPSIZE   = 3'd4,
        GRP_ADDRSIZE = 3'd5
    } prefix_group_e;

    typedef enum logic [1:0] {
        MN_ADD     = 2'd0,
        MN_AND     = 2'd1,
        MN_CALL    = 2'd2,
        MN_UNKNOWN = 2'd3
    } mnemonic_e;

    // Operand size of the instruction
    typedef enum logic [1:0] {
        SIZE8  = 2'b00,
        SIZE16 = 2'b01,
        SIZE32 = 2'b10
    } data_size_e;

    // Holds 0 up to a full queue
    typedef logic [$clog2(`QUEUE_BYTES + 1)-1:0] q_count_t;

    // Head of the byte queue as seen by the decoder
    typedef struct packed {
        logic [31:0]                    addr;       // Address of bytes[0]
        q_count_t                       count;      // Valid bytes in queue
        logic [`WINDOW_BYTES-1:0][7:0]  bytes;      // bytes[0] is next to decode
    } byte_window_t;

    // One decoded instruction
    typedef struct packed {
        logic [31:0]    addr;
        logic [3:0]     length;         // Prefixes included
        mnemonic_e      mnemonic;
        data_size_e     size;
        logic           direction;      // Opcode bit 1
        logic           immediate;      // Opcode bit 7
        logic [7:0]     modrm;          // Zero without a ModR/M byte
        logic           opsize;         // 0x66 seen
        logic [2:0]     prefix_count;
    } instr_info_t;

endpackage

// File: src/byte_classifier.sv
`include "x86_len_decoder_defines.svh"

module byte_classifier (
    input  logic [7:0]                      i_byte,
    output x86_decode_pkg::prefix_group_e   o_group
);
    import x86_decode_pkg::*;

    always_comb begin
        case (i_byte)
            `PFX_LOCK: begin
                o_group = GRP_LOCK;
            end
            `PFX_REPNE,
            `PFX_REP: begin
                o_group = GRP_REP;
            end
            `PFX_CS,
            `PFX_SS,
            `PFX_DS,
            `PFX_ES,
            `PFX_FS,
            `PFX_GS: begin
                o_group = GRP_SEG;                  // Counted only
            end
            `PFX_OPSIZE: begin
                o_group = GRP_OPSIZE;
            end
            `PFX_ADDRSIZE: begin
                o_group = GRP_ADDRSIZE;             // Counted only
            end
            default: begin
                o_group = GRP_NONE;                 // Opcode or operand byte
            end
        endcase
    end

endmodule

// File: src/fetch_queue.sv
`include "x86_len_decoder_defines.svh"

module fetch_queue (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_word_valid,
    input  logic [`WORD_BITS-1:0]           i_word,
    input  logic                            i_consume,
    input  logic [3:0]                      i_consume_len,
    output x86_decode_pkg::byte_window_t    o_window,
    output logic                            o_overflow
);
    import x86_decode_pkg::*;

    localparam int WORD_BYTES = `WORD_BITS / 8;

    logic                           have_start;     // Start address captured
    logic [31:0]                    head_addr;
    q_count_t                       fill;
    logic [`QUEUE_BYTES-1:0][7:0]   queue;

    q_count_t                       fill_kept;
    logic [`QUEUE_BYTES-1:0][7:0]   queue_kept;
    logic [`QUEUE_BYTES-1:0][7:0]   queue_next;
    logic                           append;
    logic                           no_room;

    // Removal of decoded bytes comes first
    always_comb begin
        fill_kept  = fill;
        queue_kept = queue;
        if (i_consume) begin
            fill_kept  = fill - q_count_t'(i_consume_len);
            queue_kept = queue >> {i_consume_len, 3'b000};   // Zeros shift in at the top
        end
    end

    assign append  = i_word_valid && have_start;
    assign no_room = (fill_kept + q_count_t'(WORD_BYTES)) > q_count_t'(`QUEUE_BYTES);

    // New word lands right above the kept bytes
    always_comb begin
        queue_next = queue_kept;
        if (append && !no_room) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                queue_next[fill_kept + i] = i_word[8*i +: 8];   // LSB first
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            have_start <= 1'b0;
            fill       <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (i_word_valid && !have_start) begin
                have_start <= 1'b1;
            end
            if (append && no_room) begin
                o_overflow <= 1'b1;                 // Word dropped and flag sticks
                fill       <= fill_kept;
            end else if (append) begin
                fill <= fill_kept + q_count_t'(WORD_BYTES);
            end else begin
                fill <= fill_kept;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_word_valid && !have_start) begin
            head_addr <= i_word;                    // First word is the start address
        end else if (i_consume) begin
            head_addr <= head_addr + 32'(i_consume_len);
        end
        queue <= queue_next;
    end

    assign o_window.addr  = head_addr;
    assign o_window.count = fill;
    assign o_window.bytes = queue[`WINDOW_BYTES-1:0];

endmodule

// File: src/instr_assembler.sv
`include "x86_len_decoder_defines.svh"

module instr_assembler (
    input  logic                                                i_clk,
    input  logic                                                i_reset,
    input  x86_decode_pkg::byte_window_t                        i_window,
    input  x86_decode_pkg::prefix_group_e [`CLASS_BYTES-1:0]    i_groups,
    output logic                                                o_consume,
    output logic [3:0]                                          o_consume_len,
    output logic                                                o_instr_valid,
    output x86_decode_pkg::instr_info_t                         o_instr
);
    import x86_decode_pkg::*;

    localparam int IDX_BITS = $clog2(`WINDOW_BYTES);
    localparam int NUM_PFX  = `CLASS_BYTES - 1;

    // Prefix groups in the order they may appear
    localparam prefix_group_e PFX_ORDER [NUM_PFX] = '{
        GRP_LOCK, GRP_REP, GRP_SEG, GRP_OPSIZE, GRP_ADDRSIZE
    };

    logic [2:0]             pfx_count;
    logic                   opsize;
    logic [7:0]             opcode;
    logic [IDX_BITS-1:0]    modrm_idx;
    logic [7:0]             modrm;
    mnemonic_e              mnemonic;
    data_size_e             size;
    logic                   has_modrm;
    logic [4:0]             need_len;               // Total bytes of this instruction
    instr_info_t            record;

    // SIB, displacement and immediate bytes after the ModR/M byte
    function automatic logic [3:0] operand_bytes(
        input logic [7:0]   rm_byte,
        input data_size_e   op_size,
        input logic         dir,
        input logic         imm
    );
        logic [3:0] n;
        n = 4'd0;
        case (rm_byte[7:6])
            2'b00: begin
                if (rm_byte[2:0] == 3'b100) begin
                    n = 4'd5;                       // SIB and disp32
                end else if (rm_byte[2:0] == 3'b101) begin
                    n = 4'd4;
                end
            end
            2'b01: begin
                if (rm_byte[2:0] == 3'b100) begin
                    n = 4'd2;                       // SIB and disp8
                end else if (rm_byte[2:0] == 3'b101) begin
                    n = 4'd1;
                end
            end
            2'b10: begin
                n = 4'd4;
            end
            default: begin
                if (imm) begin
                    if (op_size == SIZE8 || dir) begin
                        n = 4'd1;
                    end else if (op_size == SIZE16) begin
                        n = 4'd2;
                    end else begin
                        n = 4'd4;
                    end
                end
            end
        endcase
        return n;
    endfunction

    // Prefix walk with each group at most once
    always_comb begin
        pfx_count = 3'd0;
        opsize    = 1'b0;
        for (int k = 0; k < NUM_PFX; k++) begin
            if ((pfx_count < i_window.count) && (i_groups[pfx_count] == PFX_ORDER[k])) begin
                if (PFX_ORDER[k] == GRP_OPSIZE) begin
                    opsize = 1'b1;
                end
                pfx_count = pfx_count + 3'd1;
            end
        end
    end

    assign opcode    = i_window.bytes[pfx_count];
    assign modrm_idx = IDX_BITS'(pfx_count) + 1'b1;
    assign modrm     = i_window.bytes[modrm_idx];

    always_comb begin
        if (opcode inside {[8'h00:8'h05], 8'h80, 8'h81, 8'h83}) begin
            mnemonic = MN_ADD;
        end else if (opcode inside {[8'h20:8'h25]}) begin
            mnemonic = MN_AND;
        end else if (opcode inside {8'hE8, 8'hFF, 8'h9A}) begin
            mnemonic = MN_CALL;
        end else begin
            mnemonic = MN_UNKNOWN;                  // Includes 0x0F escape
        end
    end

    assign has_modrm = (mnemonic != MN_UNKNOWN) && (opcode != 8'hE8);
    assign size      = !opcode[0] ? SIZE8 : (opsize ? SIZE16 : SIZE32);

    always_comb begin
        if (mnemonic == MN_UNKNOWN) begin
            need_len = 5'(pfx_count) + 5'd1;        // Skip the opcode alone
        end else if (!has_modrm) begin
            need_len = 5'(pfx_count) + 5'd5;        // E8 with rel32
        end else begin
            need_len = 5'(pfx_count) + 5'd2
                     + 5'(operand_bytes(modrm, size, opcode[1], opcode[7]));
        end
    end

    // Fire only once every needed byte is in the queue
    always_comb begin
        o_consume = 1'b0;
        if (pfx_count < i_window.count) begin
            if (!has_modrm || (5'(pfx_count) + 5'd1 < i_window.count)) begin
                if (need_len <= i_window.count) begin
                    o_consume = 1'b1;
                end
            end
        end
    end

    assign o_consume_len = need_len[3:0];

    always_comb begin
        record.addr         = i_window.addr;
        record.length       = need_len[3:0];
        record.mnemonic     = mnemonic;
        record.size         = size;
        record.direction    = opcode[1];
        record.immediate    = opcode[7];
        record.modrm        = has_modrm ? modrm : 8'h00;
        record.opsize       = opsize;
        record.prefix_count = pfx_count;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_instr_valid <= 1'b0;
        end else begin
            o_instr_valid <= o_consume;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_consume) begin
            o_instr <= record;
        end
    end

endmodule

// File: src/x86_len_decoder.sv
`include "x86_len_decoder_defines.svh"

module x86_len_decoder (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_word_valid,
    input  logic [`WORD_BITS-1:0]       i_word,
    output logic                        o_instr_valid,
    output x86_decode_pkg::instr_info_t o_instr,
    output logic                        o_overflow
);
    import x86_decode_pkg::*;

    byte_window_t                       window;
    prefix_group_e [`CLASS_BYTES-1:0]   groups;
    logic                               consume;
    logic [3:0]                         consume_len;    // Bytes to drop from the head

    fetch_queue u_fetch_queue (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_word_valid   (i_word_valid),
        .i_word         (i_word),
        .i_consume      (consume),
        .i_consume_len  (consume_len),
        .o_window       (window),
        .o_overflow     (o_overflow)
    );

    // One classifier per possible prefix or opcode position
    for (genvar g = 0; g < `CLASS_BYTES; g++) begin : g_class
        byte_classifier u_byte_classifier (
            .i_byte     (window.bytes[g]),
            .o_group    (groups[g])
        );
    end

    instr_assembler u_instr_assembler (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_window       (window),
        .i_groups       (groups),
        .o_consume      (consume),
        .o_consume_len  (consume_len),
        .o_instr_valid  (o_instr_valid),
        .o_instr        (o_instr)
    );

endmodule

// File: tb/tb_x86_len_decoder.sv
`include "x86_len_decoder_defines.svh"

module tb_x86_len_decoder;
    import x86_decode_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 3;
    localparam int WORD_GAP       = 4;      // Cycles between input strobes
    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRAIN_CYCLES   = 40;     // Idle watch after the last record

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_word_valid;
    logic [`WORD_BITS-1:0]  i_word;
    logic                   o_instr_valid;
    instr_info_t            o_instr;
    logic                   o_overflow;

    logic [`WORD_BITS-1:0]  stim_words [$];
    instr_info_t            exp_records [$];
    logic [31:0]            table_addr;     // Next expected address while building
    int                     value_errors;
    int                     other_errors;
    logic                   code_sent;      // Set with the first code word
    logic                   overflow_seen;

    x86_len_decoder u_x86_len_decoder (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_word_valid   (i_word_valid),
        .i_word         (i_word),
        .o_instr_valid  (o_instr_valid),
        .o_instr        (o_instr),
        .o_overflow     (o_overflow)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    // Appends one expected record at the end of the previous one
    task automatic expect_instr(input logic [3:0] len, input mnemonic_e mn, input data_size_e sz,
                                input logic dir, input logic imm, input logic [7:0] modrm,
                                input logic opsize, input logic [2:0] pfx);
        instr_info_t rec;
        rec.addr         = table_addr;
        rec.length       = len;
        rec.mnemonic     = mn;
        rec.size         = sz;
        rec.direction    = dir;
        rec.immediate    = imm;
        rec.modrm        = modrm;
        rec.opsize       = opsize;
        rec.prefix_count = pfx;
        exp_records.push_back(rec);
        table_addr = table_addr + 32'(len);
    endtask

    task automatic build_tables();
        table_addr = 32'h0000_1000;
        stim_words.push_back(32'h0000_1000);    // Start address
        stim_words.push_back(32'hC120_C801);    // 01 C8 20 C1
        stim_words.push_back(32'h34C0_8166);    // 66 81 C0 34
        stim_words.push_back(32'h2EF3_F012);    // 12 F0 F3 2E
        stim_words.push_back(32'h0401_C801);    // 01 C8 01 04
        stim_words.push_back(32'h3456_7824);    // 24 78 56 34
        stim_words.push_back(32'h0845_0112);    // 12 01 45 08
        stim_words.push_back(32'h0010_8001);    // 01 80 10 00
        stim_words.push_back(32'hC083_0000);    // 00 00 83 C0
        stim_words.push_back(32'h0010_E805);    // 05 E8 10 00
        stim_words.push_back(32'h6690_0000);    // 00 00 90 66
        stim_words.push_back(32'h03D8_210F);    // 0F 21 D8 03
        stim_words.push_back(32'h0080_01C8);    // C8 then 01 80 00 that never completes

        expect_instr(4'd2, MN_ADD,     SIZE32, 1'b0, 1'b0, 8'hC8, 1'b0, 3'd0);   // 01 C8
        expect_instr(4'd2, MN_AND,     SIZE8,  1'b0, 1'b0, 8'hC1, 1'b0, 3'd0);   // 20 C1
        expect_instr(4'd5, MN_ADD,     SIZE16, 1'b0, 1'b1, 8'hC0, 1'b1, 3'd1);   // imm16
        expect_instr(4'd5, MN_ADD,     SIZE32, 1'b0, 1'b0, 8'hC8, 1'b0, 3'd3);   // F0 F3 2E
        expect_instr(4'd7, MN_ADD,     SIZE32, 1'b0, 1'b0, 8'h04, 1'b0, 3'd0);   // SIB disp32
        expect_instr(4'd3, MN_ADD,     SIZE32, 1'b0, 1'b0, 8'h45, 1'b0, 3'd0);   // disp8
        expect_instr(4'd6, MN_ADD,     SIZE32, 1'b0, 1'b0, 8'h80, 1'b0, 3'd0);   // disp32
        expect_instr(4'd3, MN_ADD,     SIZE32, 1'b1, 1'b1, 8'hC0, 1'b0, 3'd0);   // 83 imm8
        expect_instr(4'd5, MN_CALL,    SIZE8,  1'b0, 1'b1, 8'h00, 1'b0, 3'd0);   // E8 rel32
        expect_instr(4'd1, MN_UNKNOWN, SIZE8,  1'b0, 1'b1, 8'h00, 1'b0, 3'd0);   // 90
        expect_instr(4'd2, MN_UNKNOWN, SIZE16, 1'b1, 1'b0, 8'h00, 1'b1, 3'd1);   // 66 0F
        expect_instr(4'd2, MN_AND,     SIZE32, 1'b0, 1'b0, 8'hD8, 1'b0, 3'd0);   // 21 D8
        expect_instr(4'd2, MN_ADD,     SIZE32, 1'b1, 1'b0, 8'hC8, 1'b0, 3'd0);   // 03 C8
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            value_errors++;
            $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp_val, act_val);
        end
    endtask

    task automatic compare_record(input instr_info_t exp_rec);
        check_field("o_instr.addr",         exp_rec.addr,         o_instr.addr);
        check_field("o_instr.length",       32'(exp_rec.length),  32'(o_instr.length));
        check_field("o_instr.mnemonic",     32'(exp_rec.mnemonic), 32'(o_instr.mnemonic));
        check_field("o_instr.size",         32'(exp_rec.size),    32'(o_instr.size));
        check_field("o_instr.direction",    32'(exp_rec.direction), 32'(o_instr.direction));
        check_field("o_instr.immediate",    32'(exp_rec.immediate), 32'(o_instr.immediate));
        check_field("o_instr.modrm",        32'(exp_rec.modrm),   32'(o_instr.modrm));
        check_field("o_instr.opsize",       32'(exp_rec.opsize),  32'(o_instr.opsize));
        check_field("o_instr.prefix_count", 32'(exp_rec.prefix_count),
                    32'(o_instr.prefix_count));
    endtask

    // Overflow must never rise and is reported once
    task automatic check_status();
        if (o_overflow !== 1'b0 && !overflow_seen) begin
            overflow_seen = 1'b1;
            value_errors++;
            $display("FAILED at %0t: o_overflow expected 0x0, got 0x%0h", $time, o_overflow);
        end
    endtask

    // One strobe every WORD_GAP cycles
    task automatic send_words();
        for (int i = 0; i < stim_words.size(); i++) begin
            @(posedge i_clk);
            #1;
            i_word_valid = 1'b1;
            i_word       = stim_words[i];
            if (i > 0) begin
                code_sent = 1'b1;
            end
            @(posedge i_clk);
            #1;
            i_word_valid = 1'b0;
            repeat (WORD_GAP - 2) @(posedge i_clk);
        end
    endtask

    task automatic check_records();
        int          waited;
        logic        found;
        logic        gave_up;
        gave_up = 1'b0;
        for (int i = 0; i < exp_records.size(); i++) begin
            if (!gave_up) begin
                waited = 0;
                found  = 1'b0;
                while (!found && waited < TIMEOUT_CYCLES) begin
                    @(negedge i_clk);   // Outputs settled mid cycle
                    check_status();
                    if (o_instr_valid === 1'b1) begin
                        found = 1'b1;
                    end else begin
                        waited++;
                    end
                end
                if (!found) begin
                    other_errors++;
                    gave_up = 1'b1;
                    $display("Timed out after %0d cycles waiting for record %0d at %0t",
                             TIMEOUT_CYCLES, i, $time);
                end else begin
                    if (!code_sent) begin
                        other_errors++;
                        $display("A record came out at %0t before any code bytes were sent",
                                 $time);
                    end
                    compare_record(exp_records[i]);
                end
            end
        end
    endtask

    // The trailing partial instruction must stay in the queue
    task automatic check_no_extra();
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge i_clk);
            check_status();
            if (o_instr_valid === 1'b1) begin
                other_errors++;
                $display("Unexpected extra record at %0t with address 0x%0h",
                         $time, o_instr.addr);
            end
        end
    endtask

    initial begin
        i_reset       = 1'b1;
        i_word_valid  = 1'b0;
        i_word        = '0;
        value_errors  = 0;
        other_errors  = 0;
        code_sent     = 1'b0;
        overflow_seen = 1'b0;
        build_tables();
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        fork
            send_words();
            check_records();
        join
        check_no_extra();
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: x86_len_decoder.f
+incdir+src
src/x86_decode_pkg.sv
src/byte_classifier.sv
src/fetch_queue.sv
src/instr_assembler.sv
src/x86_len_decoder.sv
tb/tb_x86_len_decoder.sv

// File: Bender.yml
package:
  name: x86_len_decoder

sources:
  - include_dirs:
      - src
    files:
      - src/x86_decode_pkg.sv
      - src/byte_classifier.sv
      - src/fetch_queue.sv
      - src/instr_assembler.sv
      - src/x86_len_decoder.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_x86_len_decoder.sv
